//--- include/ex_cfg.svh
// Execute stage configuration constants for the RV32 integer datapath

`ifndef EX_CFG_SVH
`define EX_CFG_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Operand and result width
`define EX_DATA_W 32

// Register file address, one extra bit for the FP bank
`define EX_REG_ADDR_W 6

////////////////////////////////////////
// Multiplier
////////////////////////////////////////

// 16x16 partial products per high-half multiply
`define EX_MULT_STEPS 4

`endif

//--- verilog/ex_pkg.sv
// Shared types and operator encodings for the execute stage

`include "ex_cfg.svh"

package ex_pkg;

  // Data word and register address
  typedef logic [`EX_DATA_W-1:0]     data_t;
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

  // ALU operators, branch compares at the end
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [1:0] {
    MUL_LO,
    MUL_H,
    MUL_HSU,
    MUL_HU
  } mult_op_e;

  // High-half multiply sequence
  typedef enum logic [2:0] {
    MULT_IDLE,
    MULT_LH,
    MULT_HL,
    MULT_HH,
    MULT_DONE
  } mult_state_e;

endpackage

//--- verilog/ex_alu.sv
// Single-cycle integer ALU with shared adder, shifter and branch compare
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::data_t   operand_a_i,
  input  ex_pkg::data_t   operand_b_i,
  output ex_pkg::data_t   result_o,
  output logic            cmp_result_o
);

  localparam int SHAMT_W = $clog2(`EX_DATA_W);

  logic                  is_signed;
  logic                  is_sub;
  logic [`EX_DATA_W:0]   a_ext;
  logic [`EX_DATA_W:0]   b_ext;
  logic [`EX_DATA_W:0]   sum;
  logic                  lt;
  logic                  eq;
  ex_pkg::data_t         a_rev;
  ex_pkg::data_t         shift_src;
  logic [`EX_DATA_W:0]   shift_in;
  logic [`EX_DATA_W:0]   shift_out;
  ex_pkg::data_t         shift_rev;
  ex_pkg::data_t         shift_res;
  logic [SHAMT_W-1:0]    shamt;

  ////////////////////////////////////////
  // Adder / subtractor
  ////////////////////////////////////////

  // Signed compares extend with the sign bit and the rest with zero
  assign is_signed = operator_i inside {ex_pkg::ALU_SLT, ex_pkg::ALU_LT, ex_pkg::ALU_GE};
  // Everything but ADD subtracts
  assign is_sub    = (operator_i != ex_pkg::ALU_ADD);

  assign a_ext = {is_signed & operand_a_i[`EX_DATA_W-1], operand_a_i};
  assign b_ext = {is_signed & operand_b_i[`EX_DATA_W-1], operand_b_i};
  // Two's complement via inverted operand plus carry-in
  assign sum   = a_ext + (is_sub ? ~b_ext : b_ext) + {{`EX_DATA_W{1'b0}}, is_sub};

  // Extended MSB of the difference gives less-than
  assign lt = sum[`EX_DATA_W];
  assign eq = (sum[`EX_DATA_W-1:0] == '0);

  ////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////

  // Left shift reuses the right shifter on reversed bits
  always_comb begin
    for (int i = 0; i < `EX_DATA_W; i++) begin
      a_rev[i] = operand_a_i[`EX_DATA_W-1-i];
    end
  end

  assign shamt     = operand_b_i[SHAMT_W-1:0];
  assign shift_src = (operator_i == ex_pkg::ALU_SLL) ? a_rev : operand_a_i;
  // Extra top bit carries the fill which is the sign only for SRA
  assign shift_in  = {(operator_i == ex_pkg::ALU_SRA) & shift_src[`EX_DATA_W-1], shift_src};
  assign shift_out = $signed(shift_in) >>> shamt;

  always_comb begin
    for (int i = 0; i < `EX_DATA_W; i++) begin
      shift_rev[i] = shift_out[`EX_DATA_W-1-i];
    end
  end

  assign shift_res = (operator_i == ex_pkg::ALU_SLL) ? shift_rev :
                                                       shift_out[`EX_DATA_W-1:0];

  ////////////////////////////////////////
  // Compare and result select
  ////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ex_pkg::ALU_EQ:  cmp_result_o = eq;
      ex_pkg::ALU_NE:  cmp_result_o = ~eq;
      ex_pkg::ALU_LT,
      ex_pkg::ALU_LTU: cmp_result_o = lt;
      ex_pkg::ALU_GE,
      ex_pkg::ALU_GEU: cmp_result_o = ~lt;
      default:         cmp_result_o = 1'b0;
    endcase
  end

  always_comb begin
    case (operator_i)
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB:  result_o = sum[`EX_DATA_W-1:0];
      ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL,
      ex_pkg::ALU_SRL,
      ex_pkg::ALU_SRA:  result_o = shift_res;
      // SLT shares the branch less-than
      ex_pkg::ALU_SLT,
      ex_pkg::ALU_SLTU: result_o = {{(`EX_DATA_W-1){1'b0}}, lt};
      default:          result_o = {{(`EX_DATA_W-1){1'b0}}, cmp_result_o};
    endcase
  end

  // Adder borrow agrees with a direct compare of the operands
  always_comb begin
    assert #0 (!is_sub || lt == (is_signed ? $signed(operand_a_i) < $signed(operand_b_i)
                                           : operand_a_i < operand_b_i))
      else $error("ex_alu: adder less-than disagrees with operand compare");
  end

endmodule

//--- verilog/ex_mult.sv
// Integer multiplier with single-cycle MUL and sequenced high-half products
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_mult (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,
  input  ex_pkg::mult_op_e operator_i,
  input  ex_pkg::data_t    op_a_i,
  input  ex_pkg::data_t    op_b_i,
  input  logic             ex_ready_i,
  output ex_pkg::data_t    result_o,
  output logic             multicycle_o,
  output logic             ready_o
);

  localparam int HALF_W = `EX_DATA_W / 2;
  localparam int ACC_W  = 2 * `EX_DATA_W;
  localparam int PP_W   = 2 * HALF_W + 2;

  ex_pkg::mult_state_e    state_q;
  ex_pkg::mult_state_e    state_d;
  ex_pkg::data_t          a_q;
  ex_pkg::data_t          b_q;
  logic                   sign_a_q;
  logic                   sign_b_q;
  logic [ACC_W-1:0]       acc_q;
  logic [ACC_W-1:0]       acc_d;
  logic                   start;
  logic [HALF_W-1:0]      half_a;
  logic [HALF_W-1:0]      half_b;
  logic                   ext_a;
  logic                   ext_b;
  logic signed [PP_W-1:0] pp;
  logic [ACC_W-1:0]       pp_ext;
  ex_pkg::data_t          prod_lo;

  // MUL, low word only
  assign prod_lo = op_a_i * op_b_i;

  // High-half op accepted from idle
  assign start = enable_i && (operator_i != ex_pkg::MUL_LO) && (state_q == ex_pkg::MULT_IDLE);

  ////////////////////////////////////////
  // Partial product
  ////////////////////////////////////////

  // Pick halves per step, LL straight from the inputs
  always_comb begin
    half_a = op_a_i[HALF_W-1:0];
    half_b = op_b_i[HALF_W-1:0];
    ext_a  = 1'b0;
    ext_b  = 1'b0;
    case (state_q)
      ex_pkg::MULT_LH: begin
        half_a = a_q[HALF_W-1:0];
        half_b = b_q[`EX_DATA_W-1:HALF_W];
        ext_b  = sign_b_q & b_q[`EX_DATA_W-1];
      end
      ex_pkg::MULT_HL: begin
        half_a = a_q[`EX_DATA_W-1:HALF_W];
        half_b = b_q[HALF_W-1:0];
        ext_a  = sign_a_q & a_q[`EX_DATA_W-1];
      end
      ex_pkg::MULT_HH: begin
        half_a = a_q[`EX_DATA_W-1:HALF_W];
        half_b = b_q[`EX_DATA_W-1:HALF_W];
        ext_a  = sign_a_q & a_q[`EX_DATA_W-1];
        ext_b  = sign_b_q & b_q[`EX_DATA_W-1];
      end
      default: ;
    endcase
  end

  // 17x17 signed, low halves always positive
  assign pp     = $signed({ext_a, half_a}) * $signed({ext_b, half_b});
  assign pp_ext = {{(ACC_W-PP_W){pp[PP_W-1]}}, pp};

  ////////////////////////////////////////
  // Step FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    acc_d   = acc_q;
    ready_o = 1'b1;
    case (state_q)
      ex_pkg::MULT_IDLE: begin
        acc_d = pp_ext;
        if (start) begin
          state_d = ex_pkg::MULT_LH;
          ready_o = 1'b0;
        end
      end
      ex_pkg::MULT_LH: begin
        acc_d   = acc_q + (pp_ext << HALF_W);
        state_d = ex_pkg::MULT_HL;
        ready_o = 1'b0;
      end
      ex_pkg::MULT_HL: begin
        acc_d   = acc_q + (pp_ext << HALF_W);
        state_d = ex_pkg::MULT_HH;
        ready_o = 1'b0;
      end
      ex_pkg::MULT_HH: begin
        acc_d   = acc_q + (pp_ext << (2 * HALF_W));
        state_d = ex_pkg::MULT_DONE;
        ready_o = 1'b0;
      end
      // Hold result until EX drains
      ex_pkg::MULT_DONE: begin
        if (ex_ready_i) begin
          state_d = ex_pkg::MULT_IDLE;
        end
      end
      default: state_d = ex_pkg::MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Operand capture on start
  always_ff @(posedge clk) begin
    acc_q <= acc_d;
    if (start) begin
      a_q      <= op_a_i;
      b_q      <= op_b_i;
      sign_a_q <= (operator_i == ex_pkg::MUL_H) || (operator_i == ex_pkg::MUL_HSU);
      sign_b_q <= (operator_i == ex_pkg::MUL_H);
    end
  end

  assign multicycle_o = (state_q != ex_pkg::MULT_IDLE) && (state_q != ex_pkg::MULT_DONE);
  assign result_o     = (state_q == ex_pkg::MULT_DONE) ? acc_q[ACC_W-1:`EX_DATA_W] : prod_lo;

  // Busy for every step, then done
  assert property (@(posedge clk) disable iff (!rst_n)
    start |-> (!ready_o) [*`EX_MULT_STEPS] ##1 (state_q == ex_pkg::MULT_DONE));

  // Stalled result stays put
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ex_pkg::MULT_DONE) && !ex_ready_i
      |=> (state_q == ex_pkg::MULT_DONE) && $stable(result_o));

endmodule

//--- verilog/ex_writeback.sv
// ALU forwarding mux and EX/WB register for the LSU write port
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_writeback (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  ex_pkg::data_t     alu_result_i,
  input  ex_pkg::data_t     mult_result_i,
  input  ex_pkg::data_t     csr_rdata_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  ex_pkg::data_t     lsu_rdata_i,
  input  logic              ex_valid_i,
  input  logic              wb_ready_i,
  output ex_pkg::data_t     regfile_alu_wdata_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output logic              regfile_alu_we_fw_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::data_t     regfile_wdata_wb_o
);

  ////////////////////////////////////////
  // ALU write port
  ////////////////////////////////////////

  // CSR over MUL over ALU
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end
  end

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////

  // Idle slot with WB ready flushes the write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o <= 1'b0;
    end else if (ex_valid_i) begin
      regfile_we_wb_o <= regfile_we_i;
    end else if (wb_ready_i) begin
      regfile_we_wb_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i && regfile_we_i) begin
      regfile_waddr_wb_o <= regfile_waddr_i;
    end
  end

  // Load data goes straight to WB
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Decode enables at most one result source
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({alu_en_i, mult_en_i, csr_access_i}));

endmodule

//--- verilog/ex_stage.sv
// Execute stage top, ALU and multiplier with write ports and stall handshake
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  // ALU
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::data_t     alu_operand_a_i,
  input  ex_pkg::data_t     alu_operand_b_i,
  input  ex_pkg::data_t     alu_operand_c_i,
  input  logic              alu_en_i,
  // Multiplier
  input  ex_pkg::mult_op_e  mult_operator_i,
  input  ex_pkg::data_t     mult_operand_a_i,
  input  ex_pkg::data_t     mult_operand_b_i,
  input  logic              mult_en_i,
  output logic              mult_multicycle_o,
  // LSU and CSR
  input  logic              lsu_en_i,
  input  ex_pkg::data_t     lsu_rdata_i,
  input  logic              csr_access_i,
  input  ex_pkg::data_t     csr_rdata_i,
  // Destinations from ID
  input  logic              branch_in_ex_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_alu_we_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  // Write ports
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::data_t     regfile_wdata_wb_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::data_t     regfile_alu_wdata_fw_o,
  // To IF
  output ex_pkg::data_t     jump_target_o,
  output logic              branch_decision_o,
  // Handshake
  input  logic              lsu_ready_ex_i,
  input  logic              wb_ready_i,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  ex_pkg::data_t alu_result;
  ex_pkg::data_t mult_result;
  logic          alu_cmp_result;
  logic          mult_ready;
  logic          units_ready;

  ex_alu alu_i (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ex_writeback wb_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .ex_valid_i             (ex_valid_o),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o)
  );

  // Branch resolves in EX
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ////////////////////////////////////////
  // Stall handshake
  ////////////////////////////////////////

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;
  // Branches finish here, no need to wait on WB
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  // Valid does not look at ex_ready_o
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

//--- test/tb_ex_stage.sv
// Self-checking testbench for the RV32 execute stage
`timescale 1ns/1ps
`include "ex_cfg.svh"

module tb_ex_stage;

  localparam int     W            = `EX_DATA_W;
  localparam int     SH_W         = $clog2(`EX_DATA_W);
  localparam int     N_INSTR      = 91;
  localparam int     ACCEPT_LIMIT = 50;
  // 200 cycles per instruction plus reset at 10 ns per cycle
  localparam longint WATCHDOG_NS  = (N_INSTR * 200 + 10) * 10;

  logic              clk = 1'b0;
  logic              rst_n;
  ex_pkg::alu_op_e   alu_operator_i;
  ex_pkg::data_t     alu_operand_a_i;
  ex_pkg::data_t     alu_operand_b_i;
  ex_pkg::data_t     alu_operand_c_i;
  logic              alu_en_i;
  ex_pkg::mult_op_e  mult_operator_i;
  ex_pkg::data_t     mult_operand_a_i;
  ex_pkg::data_t     mult_operand_b_i;
  logic              mult_en_i;
  logic              mult_multicycle_o;
  logic              lsu_en_i;
  ex_pkg::data_t     lsu_rdata_i;
  logic              csr_access_i;
  ex_pkg::data_t     csr_rdata_i;
  logic              branch_in_ex_i;
  ex_pkg::reg_addr_t regfile_alu_waddr_i;
  logic              regfile_alu_we_i;
  logic              regfile_we_i;
  ex_pkg::reg_addr_t regfile_waddr_i;
  ex_pkg::reg_addr_t regfile_waddr_wb_o;
  logic              regfile_we_wb_o;
  ex_pkg::data_t     regfile_wdata_wb_o;
  ex_pkg::reg_addr_t regfile_alu_waddr_fw_o;
  logic              regfile_alu_we_fw_o;
  ex_pkg::data_t     regfile_alu_wdata_fw_o;
  ex_pkg::data_t     jump_target_o;
  logic              branch_decision_o;
  logic              lsu_ready_ex_i;
  logic              wb_ready_i;
  logic              ex_ready_o;
  logic              ex_valid_o;

  int                errors;
  int                issued;
  // Cycle index inside a high-half multiply or -1 outside one
  int                hi_phase;
  logic              took_q;
  ex_pkg::data_t     exp_data;
  logic              exp_cmp;

  ex_stage uut (.*);

  always #5 clk = ~clk;

  // Handshake seen at the last rising edge
  always @(posedge clk) begin
    took_q <= ex_valid_o;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic cmp_model(input ex_pkg::alu_op_e op, input ex_pkg::data_t a,
                                     input ex_pkg::data_t b);
    case (op)
      ex_pkg::ALU_EQ:  return a == b;
      ex_pkg::ALU_NE:  return a != b;
      ex_pkg::ALU_LT:  return $signed(a) < $signed(b);
      ex_pkg::ALU_GE:  return $signed(a) >= $signed(b);
      ex_pkg::ALU_LTU: return a < b;
      ex_pkg::ALU_GEU: return a >= b;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic ex_pkg::data_t alu_model(input ex_pkg::alu_op_e op, input ex_pkg::data_t a,
                                              input ex_pkg::data_t b);
    logic [SH_W-1:0] sh;
    sh = b[SH_W-1:0];
    case (op)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_SLL:  return a << sh;
      ex_pkg::ALU_SRL:  return a >> sh;
      ex_pkg::ALU_SRA:  return ex_pkg::data_t'($signed(a) >>> sh);
      ex_pkg::ALU_SLT:  return {{(W-1){1'b0}}, $signed(a) < $signed(b)};
      ex_pkg::ALU_SLTU: return {{(W-1){1'b0}}, a < b};
      default:          return {{(W-1){1'b0}}, cmp_model(op, a, b)};
    endcase
  endfunction

  // Upper word of the 64-bit product with per-operator signs
  function automatic ex_pkg::data_t mul_hi_model(input ex_pkg::mult_op_e op,
                                                 input ex_pkg::data_t a, input ex_pkg::data_t b);
    logic           sa;
    logic           sb;
    logic [2*W-1:0] ea;
    logic [2*W-1:0] eb;
    logic [2*W-1:0] p;
    sa = (op == ex_pkg::MUL_H) || (op == ex_pkg::MUL_HSU);
    sb = (op == ex_pkg::MUL_H);
    ea = {{W{sa & a[W-1]}}, a};
    eb = {{W{sb & b[W-1]}}, b};
    p  = ea * eb;
    return p[2*W-1:W];
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    errors++;
    $display("MISMATCH %0t: %s", $time, msg);
  endtask

  a_alu: assert property (@(posedge clk) disable iff (!rst_n)
    alu_en_i |-> regfile_alu_wdata_fw_o == exp_data && branch_decision_o == exp_cmp)
    else report_mismatch("ALU result or branch decision");

  a_done: assert property (@(posedge clk) disable iff (!rst_n)
    (alu_en_i || csr_access_i || lsu_en_i || (mult_en_i && mult_operator_i == ex_pkg::MUL_LO))
      && wb_ready_i && lsu_ready_ex_i |-> ex_valid_o && ex_ready_o)
    else report_mismatch("single-cycle op not valid");

  a_jump: assert property (@(posedge clk) disable iff (!rst_n)
    jump_target_o == alu_operand_c_i)
    else report_mismatch("jump target");

  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    branch_in_ex_i |-> ex_ready_o)
    else report_mismatch("branch did not force ready");

  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (!wb_ready_i || !lsu_ready_ex_i) && !branch_in_ex_i |-> !ex_ready_o && !ex_valid_o)
    else report_mismatch("ready or valid under back-pressure");

  a_mul_lo: assert property (@(posedge clk) disable iff (!rst_n)
    mult_en_i && mult_operator_i == ex_pkg::MUL_LO |-> regfile_alu_wdata_fw_o == exp_data)
    else report_mismatch("MUL low word");

  // Start cycle plus three busy steps
  a_hi_busy: assert property (@(posedge clk) disable iff (!rst_n)
    hi_phase >= 0 && hi_phase < 4 |-> !ex_ready_o && !ex_valid_o
      && mult_multicycle_o == (hi_phase != 0))
    else report_mismatch($sformatf("high-half busy phase %0d", hi_phase));

  a_hi_data: assert property (@(posedge clk) disable iff (!rst_n)
    hi_phase >= 4 |-> regfile_alu_wdata_fw_o == exp_data && !mult_multicycle_o)
    else report_mismatch("high-half result");

  a_hi_valid: assert property (@(posedge clk) disable iff (!rst_n)
    hi_phase >= 4 && wb_ready_i && lsu_ready_ex_i |-> ex_valid_o)
    else report_mismatch("high-half result not valid");

  a_csr: assert property (@(posedge clk) disable iff (!rst_n)
    csr_access_i |-> regfile_alu_wdata_fw_o == csr_rdata_i)
    else report_mismatch("CSR forwarding data");

  a_fw_dest: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_alu_we_fw_o == regfile_alu_we_i && regfile_alu_waddr_fw_o == regfile_alu_waddr_i)
    else report_mismatch("forwarding destination");

  a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_wdata_wb_o == lsu_rdata_i)
    else report_mismatch("LSU write data");

  a_wb_we: assert property (@(posedge clk) disable iff (!rst_n)
    $past(ex_valid_o && regfile_we_i) |-> regfile_we_wb_o
      && regfile_waddr_wb_o == $past(regfile_waddr_i))
    else report_mismatch("EX/WB write enable or address");

  a_wb_clr: assert property (@(posedge clk) disable iff (!rst_n)
    $past(!ex_valid_o && wb_ready_i) |-> !regfile_we_wb_o)
    else report_mismatch("EX/WB write not cleared");

  a_rst: assert property (@(posedge clk) !rst_n |-> !regfile_we_wb_o && !mult_multicycle_o)
    else report_mismatch("outputs active in reset");

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic clear_instr();
    alu_en_i       = 1'b0;
    mult_en_i      = 1'b0;
    csr_access_i   = 1'b0;
    lsu_en_i       = 1'b0;
    branch_in_ex_i = 1'b0;
    regfile_we_i   = 1'b0;
    wb_ready_i     = 1'b1;
    lsu_ready_ex_i = 1'b1;
    hi_phase       = -1;
  endtask

  // Holds the instruction until EX takes it and releases stalls after the given cycles
  task automatic wait_accept(input int bp_wb, input int bp_lsu, input bit hi);
    int n;
    n = 0;
    do begin
      wb_ready_i     = (n >= bp_wb);
      lsu_ready_ex_i = (n >= bp_lsu);
      hi_phase       = hi ? n : -1;
      @(negedge clk);
      n++;
    end while (!took_q && n < ACCEPT_LIMIT);
    if (!took_q) begin
      errors++;
      $display("ERROR %0t: instruction was never accepted by the execute stage", $time);
    end
    clear_instr();
    issued++;
  endtask

  task automatic run_alu(input ex_pkg::alu_op_e op, input ex_pkg::data_t a,
                         input ex_pkg::data_t b, input int bp_wb, input int bp_lsu,
                         input bit branch);
    alu_operator_i      = op;
    alu_operand_a_i     = a;
    alu_operand_b_i     = b;
    alu_operand_c_i     = ex_pkg::data_t'($urandom());
    regfile_alu_we_i    = 1'b1;
    regfile_alu_waddr_i = ex_pkg::reg_addr_t'($urandom());
    branch_in_ex_i      = branch;
    alu_en_i            = 1'b1;
    exp_data            = alu_model(op, a, b);
    exp_cmp             = cmp_model(op, a, b);
    wait_accept(bp_wb, bp_lsu, 1'b0);
  endtask

  task automatic run_mult(input ex_pkg::mult_op_e op, input ex_pkg::data_t a,
                          input ex_pkg::data_t b, input int bp_wb);
    mult_operator_i  = op;
    mult_operand_a_i = a;
    mult_operand_b_i = b;
    mult_en_i        = 1'b1;
    exp_data         = (op == ex_pkg::MUL_LO) ? a * b : mul_hi_model(op, a, b);
    wait_accept(bp_wb, 0, op != ex_pkg::MUL_LO);
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog: simulation ran past its time limit");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    ex_pkg::data_t a;
    void'($urandom(42478));
    errors              = 0;
    issued              = 0;
    exp_data            = '0;
    exp_cmp             = 1'b0;
    rst_n               = 1'b0;
    alu_operator_i      = ex_pkg::ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_operator_i     = ex_pkg::MUL_LO;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    lsu_rdata_i         = '0;
    csr_rdata_i         = '0;
    regfile_alu_waddr_i = '0;
    regfile_alu_we_i    = 1'b0;
    regfile_waddr_i     = '0;
    clear_instr();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Every ALU operator with equal operands on the first pass
    for (int op = 0; op < 16; op++) begin
      for (int k = 0; k < 4; k++) begin
        a = ex_pkg::data_t'($urandom());
        run_alu(ex_pkg::alu_op_e'(op), a, (k == 0) ? a : ex_pkg::data_t'($urandom()),
                0, 0, 1'b0);
      end
    end

    // Branch with WB stalled
    run_alu(ex_pkg::ALU_LT, ex_pkg::data_t'($urandom()), ex_pkg::data_t'($urandom()),
            2, 0, 1'b1);

    for (int k = 0; k < 4; k++) begin
      run_mult(ex_pkg::MUL_LO, ex_pkg::data_t'($urandom()), ex_pkg::data_t'($urandom()), 0);
    end

    // High halves with corner operands first
    for (int op = 1; op < 4; op++) begin
      run_mult(ex_pkg::mult_op_e'(op), 32'h8000_0000, 32'hFFFF_FFFF, 0);
      for (int k = 0; k < 3; k++) begin
        run_mult(ex_pkg::mult_op_e'(op), ex_pkg::data_t'($urandom()),
                 ex_pkg::data_t'($urandom()), 0);
      end
    end

    // Finished MULH held while WB stalls
    run_mult(ex_pkg::MUL_H, ex_pkg::data_t'($urandom()), ex_pkg::data_t'($urandom()), 7);

    for (int k = 0; k < 4; k++) begin
      csr_rdata_i         = ex_pkg::data_t'($urandom());
      regfile_alu_we_i    = 1'($urandom());
      regfile_alu_waddr_i = ex_pkg::reg_addr_t'($urandom());
      csr_access_i        = 1'b1;
      wait_accept(0, 0, 1'b0);
    end

    // Loads each followed by an idle slot
    for (int k = 0; k < 4; k++) begin
      lsu_rdata_i     = ex_pkg::data_t'($urandom());
      regfile_waddr_i = ex_pkg::reg_addr_t'($urandom());
      regfile_we_i    = 1'b1;
      lsu_en_i        = 1'b1;
      wait_accept(0, 0, 1'b0);
      @(negedge clk);
    end

    // LSU not ready
    run_alu(ex_pkg::ALU_ADD, ex_pkg::data_t'($urandom()), ex_pkg::data_t'($urandom()),
            0, 3, 1'b0);
    repeat (2) @(negedge clk);

    $display("Summary: %0d instructions issued, %0d errors", issued, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_writeback.sv
verilog/ex_stage.sv
test/tb_ex_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module tb_ex_stage \
  && out="$(./obj_dir/Vtb_ex_stage)" \
  && echo "$out" \
  && grep -q "Done: no errors" <<< "$out" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
